/* logic/lsu_pkg.sv */
package lsu_pkg;

    localparam int XLEN = 32;

    // major opcodes, only load and store are acted on
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 of the store group
    typedef enum logic [2:0] {
        FNC_SB = 3'b000,
        FNC_SH = 3'b001,
        FNC_SW = 3'b010
    } store_fn_e;

    // funct3 of the load group
    typedef enum logic [2:0] {
        FNC_LB  = 3'b000,
        FNC_LH  = 3'b001,
        FNC_LW  = 3'b010,
        FNC_LBU = 3'b100,
        FNC_LHU = 3'b101
    } load_fn_e;

    typedef enum logic [1:0] {
        ACC_NONE  = 2'b00,
        ACC_LOAD  = 2'b01,
        ACC_STORE = 2'b10
    } access_e;

endpackage

/* logic/mem_request_decode.sv */
`timescale 1ns/100ps

module mem_request_decode import lsu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            req_valid,
    input  logic [XLEN-1:0] instruction,
    input  logic [XLEN-1:0] rs1_value,
    input  logic [XLEN-1:0] rs2_value,
    output logic            acc_valid,
    output access_e         acc_kind,
    output logic [2:0]      acc_funct3,
    output logic [XLEN-1:0] acc_addr,
    output logic [XLEN-1:0] acc_store_data
);

    opcode_e         opcode;
    access_e         kind;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] offset;
    logic [XLEN-1:0] eff_addr;

    assign opcode = opcode_e'(instruction[6:0]);

    // sign extended immediates, I type for loads, S type for stores
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};

    always_comb begin
        case (opcode)
            OPC_LOAD: begin
                kind   = ACC_LOAD;
                offset = imm_i;
            end
            OPC_STORE: begin
                kind   = ACC_STORE;
                offset = imm_s;
            end
            default: begin
                kind   = ACC_NONE; // anything else is a no-op here
                offset = imm_i;
            end
        endcase
    end

    assign eff_addr = rs1_value + offset;

    // stage 1 control
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_valid <= 1'b0;
            acc_kind  <= ACC_NONE;
        end else begin
            acc_valid <= req_valid;
            acc_kind  <= req_valid ? kind : ACC_NONE;
        end
    end

    // stage 1 payload
    always_ff @(posedge clk) begin
        if (req_valid) begin
            acc_funct3     <= instruction[14:12];
            acc_addr       <= eff_addr;
            acc_store_data <= rs2_value;
        end
    end

endmodule

/* logic/partial_store.sv */
`timescale 1ns/100ps

module partial_store import lsu_pkg::*; (
    input  logic            acc_valid,
    input  access_e         acc_kind,
    input  logic [2:0]      acc_funct3,
    input  logic [XLEN-1:0] acc_addr,
    input  logic [XLEN-1:0] acc_store_data,
    output logic [XLEN-1:0] data_to_mem,
    output logic [3:0]      mem_write_mask,
    output logic            store_fault
);

    store_fn_e fn;

    assign fn = store_fn_e'(acc_funct3);

    always_comb begin
        data_to_mem    = acc_store_data;
        mem_write_mask = 4'b0000;
        store_fault    = 1'b0;
        if (acc_valid && (acc_kind == ACC_STORE)) begin
            case (fn)
                FNC_SB: begin
                    case (acc_addr[1:0])
                        2'b00: begin
                            data_to_mem    = {24'h0, acc_store_data[7:0]};
                            mem_write_mask = 4'b0001;
                        end
                        2'b01: begin
                            data_to_mem    = {16'h0, acc_store_data[7:0], 8'h0};
                            mem_write_mask = 4'b0010;
                        end
                        2'b10: begin
                            data_to_mem    = {8'h0, acc_store_data[7:0], 16'h0};
                            mem_write_mask = 4'b0100;
                        end
                        default: begin
                            data_to_mem    = {acc_store_data[7:0], 24'h0};
                            mem_write_mask = 4'b1000;
                        end
                    endcase
                end
                FNC_SH: begin
                    if (acc_addr[1:0] == 2'b00) begin
                        data_to_mem    = {16'h0, acc_store_data[15:0]};
                        mem_write_mask = 4'b0011;
                    end else if (acc_addr[1:0] == 2'b10) begin
                        data_to_mem    = {acc_store_data[15:0], 16'h0};
                        mem_write_mask = 4'b1100;
                    end else begin
                        store_fault = 1'b1; // odd halfword address
                    end
                end
                FNC_SW: begin
                    if (acc_addr[1:0] == 2'b00) begin
                        mem_write_mask = 4'b1111;
                    end else begin
                        store_fault = 1'b1;
                    end
                end
                default: store_fault = 1'b1; // unused funct3
            endcase
        end
    end

endmodule

/* logic/byte_mask_ram.sv */
`timescale 1ns/100ps

module byte_mask_ram import lsu_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic [XLEN-1:0] mem_addr,
    input  logic [3:0]      mem_write_mask,
    input  logic [XLEN-1:0] data_to_mem,
    input  logic            mem_read_en,
    output logic [XLEN-1:0] mem_read_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;

    // upper address bits dropped, so accesses wrap
    assign word_idx = mem_addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (mem_write_mask[lane]) begin
                mem[word_idx][8*lane +: 8] <= data_to_mem[8*lane +: 8];
            end
        end
    end

    // registered read, one edge after the address
    always_ff @(posedge clk) begin
        if (mem_read_en) begin
            mem_read_data <= mem[word_idx];
        end
    end

endmodule

/* logic/partial_load.sv */
`timescale 1ns/100ps

module partial_load import lsu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            acc_valid,
    input  access_e         acc_kind,
    input  logic [2:0]      acc_funct3,
    input  logic [XLEN-1:0] acc_addr,
    input  logic            store_fault,
    input  logic [XLEN-1:0] mem_read_data,
    output logic            rsp_valid,
    output logic [XLEN-1:0] rsp_data,
    output logic            fault_valid
);

    load_fn_e        fn_s1;
    load_fn_e        fn_s2;
    logic            load_fault;
    access_e         s2_kind;
    logic            s2_fault;
    logic [2:0]      s2_funct3;
    logic [1:0]      s2_lane;
    logic [7:0]      sel_byte;
    logic [15:0]     sel_half;
    logic [XLEN-1:0] load_value;

    assign fn_s1 = load_fn_e'(acc_funct3);

    always_comb begin
        case (fn_s1)
            FNC_LB, FNC_LBU: load_fault = 1'b0;
            FNC_LH, FNC_LHU: load_fault = acc_addr[0];
            FNC_LW:          load_fault = (acc_addr[1:0] != 2'b00);
            default:         load_fault = 1'b1;
        endcase
    end

    // stage 2, lines up with the ram read
    always_ff @(posedge clk) begin
        if (reset) begin
            s2_kind  <= ACC_NONE;
            s2_fault <= 1'b0;
        end else begin
            s2_kind  <= acc_valid ? acc_kind : ACC_NONE;
            s2_fault <= store_fault | (acc_valid && (acc_kind == ACC_LOAD) && load_fault);
        end
    end

    always_ff @(posedge clk) begin
        s2_funct3 <= acc_funct3;
        s2_lane   <= acc_addr[1:0];
    end

    assign fn_s2    = load_fn_e'(s2_funct3);
    assign sel_byte = mem_read_data[{s2_lane, 3'b000} +: 8];
    assign sel_half = s2_lane[1] ? mem_read_data[31:16] : mem_read_data[15:0];

    always_comb begin
        case (fn_s2)
            FNC_LB:  load_value = {{24{sel_byte[7]}}, sel_byte};
            FNC_LH:  load_value = {{16{sel_half[15]}}, sel_half};
            FNC_LBU: load_value = {24'h0, sel_byte};
            FNC_LHU: load_value = {16'h0, sel_half};
            default: load_value = mem_read_data; // LW
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid   <= 1'b0;
            fault_valid <= 1'b0;
        end else begin
            rsp_valid   <= (s2_kind == ACC_LOAD) && !s2_fault;
            fault_valid <= s2_fault;
        end
    end

    always_ff @(posedge clk) begin
        if ((s2_kind == ACC_LOAD) && !s2_fault) begin
            rsp_data <= load_value;
        end
    end

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            req_valid,
    input  logic [XLEN-1:0] instruction,
    input  logic [XLEN-1:0] rs1_value,
    input  logic [XLEN-1:0] rs2_value,
    output logic            rsp_valid,
    output logic [XLEN-1:0] rsp_data,
    output logic            fault_valid
);

    logic            acc_valid;
    access_e         acc_kind;
    logic [2:0]      acc_funct3;
    logic [XLEN-1:0] acc_addr;
    logic [XLEN-1:0] acc_store_data;
    logic [XLEN-1:0] data_to_mem;
    logic [3:0]      mem_write_mask;
    logic            store_fault;
    logic            mem_read_en;
    logic [XLEN-1:0] mem_read_data;

    mem_request_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .instruction    (instruction),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .acc_valid      (acc_valid),
        .acc_kind       (acc_kind),
        .acc_funct3     (acc_funct3),
        .acc_addr       (acc_addr),
        .acc_store_data (acc_store_data)
    );

    partial_store u_store (
        .acc_valid      (acc_valid),
        .acc_kind       (acc_kind),
        .acc_funct3     (acc_funct3),
        .acc_addr       (acc_addr),
        .acc_store_data (acc_store_data),
        .data_to_mem    (data_to_mem),
        .mem_write_mask (mem_write_mask),
        .store_fault    (store_fault)
    );

    // misaligned loads still read, the data is dropped later
    assign mem_read_en = acc_valid && (acc_kind == ACC_LOAD);

    byte_mask_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
        .clk            (clk),
        .mem_addr       (acc_addr),
        .mem_write_mask (mem_write_mask),
        .data_to_mem    (data_to_mem),
        .mem_read_en    (mem_read_en),
        .mem_read_data  (mem_read_data)
    );

    partial_load u_load (
        .clk            (clk),
        .reset          (reset),
        .acc_valid      (acc_valid),
        .acc_kind       (acc_kind),
        .acc_funct3     (acc_funct3),
        .acc_addr       (acc_addr),
        .store_fault    (store_fault),
        .mem_read_data  (mem_read_data),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .fault_valid    (fault_valid)
    );

endmodule

/* testbench/lsu_assertions.sv */
`timescale 1ns/100ps

module lsu_assertions (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input logic rsp_valid,
    input logic fault_valid
);

    // one result kind per cycle
    a_one_strobe: assert property (@(posedge clk) !(rsp_valid && fault_valid))
        else $error("rsp_valid and fault_valid high in the same cycle");

    a_quiet_in_reset: assert property (
        @(posedge clk) $past(reset) |-> !rsp_valid && !fault_valid
    ) else $error("response strobe during reset");

    a_quiet_after_reset: assert property (
        @(posedge clk) $past(reset, 2) |-> !rsp_valid && !fault_valid
    ) else $error("response strobe in the cycle after reset");

    // fixed latency back to the request
    a_strobe_latency: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_valid || fault_valid) |-> $past(req_valid, 3)
    ) else $error("response strobe without a request three cycles earlier");

endmodule

bind lsu_top lsu_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .rsp_valid   (rsp_valid),
    .fault_valid (fault_valid)
);

/* testbench/lsu_tb.sv */
`timescale 1ns/100ps

module lsu_tb;

    logic        clk;
    logic        reset;
    logic        req_valid;
    logic [31:0] instruction;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic        fault_valid;

    int          cycle = 0;
    int          data_errors = 0;
    int          strobe_errors = 0;
    int          other_errors = 0;

    // expected responses in issue order
    int          due_q[$];
    int          kind_q[$];
    logic [31:0] data_q[$];

    lsu_top #(.MEM_WORDS(256)) DUT (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .instruction (instruction),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .fault_valid (fault_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic issue_request(input logic [31:0] instr, input logic [31:0] rs1,
                                 input logic [31:0] rs2, input int kind,
                                 input logic [31:0] data);
        @(posedge clk);
        #1;
        req_valid   = 1'b1;
        instruction = instr;
        rs1_value   = rs1;
        rs2_value   = rs2;
        due_q.push_back(cycle + 3); // sampled next edge, strobe two edges later
        kind_q.push_back(kind);
        data_q.push_back(data);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // outputs settle right after the rising edge, so look at the falling one
    always @(negedge clk) begin
        int          exp_kind;
        logic [31:0] exp_data;

        exp_kind = 0;
        exp_data = '0;
        if (!reset) begin
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                void'(due_q.pop_front());
                exp_kind = kind_q.pop_front();
                exp_data = data_q.pop_front();
            end
            assert (rsp_valid == (exp_kind == 1)) else begin
                strobe_errors++;
                $display("%s response strobe at %0t",
                         rsp_valid ? "unexpected" : "missing", $time);
            end
            assert (fault_valid == (exp_kind == 2)) else begin
                strobe_errors++;
                $display("%s fault strobe at %0t",
                         fault_valid ? "unexpected" : "missing", $time);
            end
            if (exp_kind == 1 && rsp_valid) begin
                assert (rsp_data == exp_data) else begin
                    data_errors++;
                    $display("ERROR at %0t: rsp_data %h, expected %h",
                             $time, rsp_data, exp_data);
                end
            end
        end
    end

    initial begin
        int          fd;
        int          fields;
        int          gap;
        int          kind;
        int          drain;
        string       line;
        logic [31:0] instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] data;

        reset       = 1'b1;
        req_valid   = 1'b0;
        instruction = '0;
        rs1_value   = '0;
        rs2_value   = '0;
        void'($urandom(32'hf75));

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("testbench/lsu_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/lsu_testdata.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != 8'h23) begin // # marks a note
                    fields = $sscanf(line, "%h %h %h %d %h", instr, rs1, rs2, kind, data);
                    if (fields != 5) begin
                        $display("malformed test data line: %s", line);
                        other_errors++;
                    end else begin
                        // idle gaps only ahead of stores, loads stay back to back
                        if (instr[6:0] == 7'b0100011) begin
                            gap = $urandom_range(3, 0);
                            repeat (gap) idle_cycle();
                        end
                        issue_request(instr, rs1, rs2, kind, data);
                    end
                end
            end
            $fclose(fd);
        end
        idle_cycle();

        drain = 0;
        while (due_q.size() > 0 && drain < 16) begin
            @(posedge clk);
            drain++;
        end
        if (due_q.size() > 0) begin
            $display("timed out with %0d responses never seen", due_q.size());
            other_errors++;
        end
        repeat (4) @(posedge clk); // late strobes still get caught

        $display("error counts: %0d data, %0d strobe, %0d other",
                 data_errors, strobe_errors, other_errors);
        if (data_errors + strobe_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/lsu_testdata.txt */
# columns: instruction rs1 rs2 (hex), kind (0 none, 1 data, 2 fault), expected data (hex)
# register fields in the encodings are zero, only opcode, funct3 and immediate matter
# word store near the top of memory wraps to byte 0x008
00002823 000003f8 cafef00d 0 00000000
00002003 00000008 00000000 1 cafef00d
ffc02003 0000000c 00000000 1 cafef00d
00002003 00000408 00000000 1 cafef00d
# byte lanes of word 0x20
00002023 00000020 11223344 0 00000000
00000023 00000021 123456aa 0 00000000
00002003 00000020 00000000 1 1122aa44
00000023 00000020 deadbe55 0 00000000
00000023 00000022 00000066 0 00000000
fe000fa3 00000024 ffffff77 0 00000000
00002003 00000020 00000000 1 7766aa55
# halfwords in word 0x40, then sign and zero extension
00001023 00000040 ffff8001 0 00000000
00001123 00000040 00017ffe 0 00000000
00002003 00000040 00000000 1 7ffe8001
00001003 00000040 00000000 1 ffff8001
00005003 00000040 00000000 1 00008001
00001003 00000042 00000000 1 00007ffe
00005003 00000042 00000000 1 00007ffe
00000003 00000040 00000000 1 00000001
00000003 00000041 00000000 1 ffffff80
00104003 00000040 00000000 1 00000080
00300003 00000040 00000000 1 0000007f
00004003 00000042 00000000 1 000000fe
00000003 00000042 00000000 1 fffffffe
# store then loads back to back, three in flight
00002023 00000080 0badcafe 0 00000000
00002003 00000080 00000000 1 0badcafe
00000003 00000080 00000000 1 fffffffe
00005003 00000082 00000000 1 00000bad
# misaligned accesses and unused funct3 fault and write nothing
00001023 00000041 0000dead 2 00000000
000020a3 00000020 ffffffff 2 00000000
00001003 00000043 00000000 2 00000000
00002003 00000041 00000000 2 00000000
00003023 00000040 ffffffff 2 00000000
00003003 00000040 00000000 2 00000000
00002003 00000020 00000000 1 7766aa55
00002003 00000040 00000000 1 7ffe8001
# other opcodes do nothing
00000013 00000040 ffffffff 0 00000000
00002033 00000040 ffffffff 0 00000000
0000006f 00000000 00000000 0 00000000
00002003 00000040 00000000 1 7ffe8001

/* sources.f */
logic/lsu_pkg.sv
logic/mem_request_decode.sv
logic/partial_store.sv
logic/byte_mask_ram.sv
logic/partial_load.sv
logic/lsu_top.sv
testbench/lsu_assertions.sv
testbench/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the lsu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module lsu_tb -f sources.f -o lsu_sim

out=$(./obj_dir/lsu_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi
